// ==== testbench/mbox_input.txt ====
# port kind addr data strb expect resp, all but port and kind in hex
# kind 0 write, 1 read (expect is the lane word), 2 wait data cycles for irq == expect
0 0 40000000 11111111 f 0 0
0 0 40000004 22222222 f 0 0
0 0 40000000 33333333 f 0 0
1 1 40000004 0 0 11111111 0
1 1 40000000 0 0 22222222 0
1 1 40000004 0 0 33333333 0
1 0 40000004 a5a50001 f 0 0
1 0 40000000 a5a50002 f 0 0
0 1 40000000 0 0 a5a50001 0
0 1 40000004 0 0 a5a50002 0
# byte strobes
0 0 40000004 a1b2c3d4 5 0 0
1 1 40000000 0 0 00b200d4 0
0 0 40000018 00001234 3 0 0
0 0 40000018 0000abcd 2 0 0
0 1 40000018 0 0 0000ab34 0
0 0 40000018 0 3 0 0
# status, empty read, overflow
1 1 40000008 0 0 00000001 0
1 1 40000000 0 0 00000000 2
0 0 40000000 10000001 f 0 0
0 0 40000004 10000002 f 0 0
0 0 40000000 10000003 f 0 0
0 0 40000004 10000004 f 0 0
0 0 40000000 10000005 f 0 0
0 0 40000004 10000006 f 0 0
0 0 40000000 10000007 f 0 0
0 0 40000004 10000008 f 0 0
0 1 40000008 0 0 00000003 0
1 1 40000008 0 0 00000020 0
0 0 40000004 10000009 f 0 2
1 1 40000000 0 0 10000001 0
1 1 40000004 0 0 10000002 0
1 1 40000000 0 0 10000003 0
1 1 40000008 0 0 00000014 0
1 1 40000004 0 0 10000004 0
1 1 40000000 0 0 10000005 0
1 1 40000004 0 0 10000006 0
1 1 40000000 0 0 10000007 0
1 1 40000004 0 0 10000008 0
1 1 40000000 0 0 00000000 2
# threshold interrupt at port 1
1 0 40000010 00000003 1 0 0
0 0 40000000 c0de0001 f 0 0
0 0 40000004 c0de0002 f 0 0
1 2 0 0 0 0 0
0 0 40000000 c0de0003 f 0 0
1 2 0 4 0 1 0
1 1 40000000 0 0 c0de0001 0
1 2 0 4 0 0 0
1 1 40000004 0 0 c0de0002 0
1 1 40000000 0 0 c0de0003 0
1 0 40000010 0 1 0 0
# timeout interrupt at port 1
1 0 40000018 00000014 3 0 0
0 0 40000000 beef0001 f 0 0
1 2 0 0 0 0 0
1 2 0 28 0 1 0
1 1 40000000 0 0 beef0001 0
1 2 0 4 0 0 0
1 0 40000018 0 3 0 0

// ==== sim.f ====
hdl/mbox_pkg.sv
hdl/mbox_fifo.sv
hdl/mbox_irq_timer.sv
hdl/mbox_access_fsm.sv
hdl/mbox_port_adapter.sv
hdl/mbox_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mbox.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mailbox testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module tb_mbox -o tb_mbox

out=$(./obj_dir/tb_mbox)
echo "$out"

if grep -q "Simulation PASSED" <<< "$out"
then
   exit 0
fi
exit 1

// ==== testbench/tb_mbox.sv ====
`timescale 1ns/1ps

module tb_mbox;

   import mbox_pkg::*;

   localparam int WAIT_LIMIT = 50;

   logic        Clk_CI;
   logic        Rst_RBI;
   aw_chan_t    aw [2];
   logic [1:0]  aw_valid;
   logic [1:0]  aw_ready;
   w_chan_t     w [2];
   logic [1:0]  w_valid;
   logic [1:0]  w_ready;
   b_chan_t     b [2];
   logic [1:0]  b_valid;
   logic [1:0]  b_ready;
   ar_chan_t    ar [2];
   logic [1:0]  ar_valid;
   logic [1:0]  ar_ready;
   r_chan_t     r [2];
   logic [1:0]  r_valid;
   logic [1:0]  r_ready;
   logic [1:0]  irq;

   int unsigned seed = 11475;
   int          op_errs;
   int          n_pass;
   int          n_fail;
   bit          hung;

   tb_clk_gen i_clk_gen (.Clk_CI, .Rst_RBI);

   mbox_top UUT
     (
      .Clk_CI, .Rst_RBI,
      .aw0(aw[0]), .aw0_valid(aw_valid[0]), .aw0_ready(aw_ready[0]),
      .w0(w[0]), .w0_valid(w_valid[0]), .w0_ready(w_ready[0]),
      .b0(b[0]), .b0_valid(b_valid[0]), .b0_ready(b_ready[0]),
      .ar0(ar[0]), .ar0_valid(ar_valid[0]), .ar0_ready(ar_ready[0]),
      .r0(r[0]), .r0_valid(r_valid[0]), .r0_ready(r_ready[0]),
      .aw1(aw[1]), .aw1_valid(aw_valid[1]), .aw1_ready(aw_ready[1]),
      .w1(w[1]), .w1_valid(w_valid[1]), .w1_ready(w_ready[1]),
      .b1(b[1]), .b1_valid(b_valid[1]), .b1_ready(b_ready[1]),
      .ar1(ar[1]), .ar1_valid(ar_valid[1]), .ar1_ready(ar_ready[1]),
      .r1(r[1]), .r1_valid(r_valid[1]), .r1_ready(r_ready[1]),
      .irq0(irq[0]), .irq1(irq[1])
      );

   function automatic int unsigned next_rand();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 16;
   endfunction

   task automatic compare_value(input string name, input logic [79:0] exp,
                                input logic [79:0] got);
      assert (got === exp)
      else
      begin
         $display("error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
         op_errs++;
      end
   endtask

   task automatic check_waited(input int n, input string what);
      assert (n < WAIT_LIMIT)
      else
      begin
         $display("timeout after %0d cycles waiting for %s", n, what);
         op_errs++;
         hung = 1'b1;
      end
   endtask

   task automatic write_op(input int p, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [ID_W-1:0] id,
                           input logic [1:0] exp_resp);
      w_chan_t wd;
      b_chan_t seen;
      int      n;
      int      hold;
      @(posedge Clk_CI);
      #2;
      aw[p].id     = id;
      aw[p].addr   = addr;
      aw_valid[p]  = 1'b1;
      n = 0;
      @(negedge Clk_CI);
      while (!aw_ready[p] && n < WAIT_LIMIT)
      begin
         @(negedge Clk_CI);
         n++;
      end
      check_waited(n, $sformatf("aw%0d_ready", p));
      if (hung)
         return;
      @(posedge Clk_CI);
      #2;
      aw_valid[p] = 1'b0;
      // Data trails the address by a few cycles
      repeat (2) @(posedge Clk_CI);
      #2;
      wd.data.lane[0]       = next_rand();
      wd.data.lane[1]       = next_rand();
      wd.data.lane[addr[2]] = data;
      wd.strb = addr[2] ? {strb, 4'(next_rand())} : {4'(next_rand()), strb};
      w[p]       = wd;
      w_valid[p] = 1'b1;
      n = 0;
      @(negedge Clk_CI);
      while (!w_ready[p] && n < WAIT_LIMIT)
      begin
         @(negedge Clk_CI);
         n++;
      end
      check_waited(n, $sformatf("w%0d_ready", p));
      if (hung)
         return;
      @(posedge Clk_CI);
      #2;
      w_valid[p] = 1'b0;
      n = 0;
      @(negedge Clk_CI);
      while (!b_valid[p] && n < WAIT_LIMIT)
      begin
         @(negedge Clk_CI);
         n++;
      end
      check_waited(n, $sformatf("b%0d_valid", p));
      if (hung)
         return;
      assert (n == 0)
      else
      begin
         $display("b%0d_valid came %0d cycles later than one cycle after w", p, n);
         op_errs++;
      end
      seen = b[p];
      compare_value($sformatf("b%0d.id", p), 80'(id), 80'(seen.id));
      compare_value($sformatf("b%0d.resp", p), 80'(exp_resp), 80'(seen.resp));
      hold = next_rand() % 4;
      repeat (hold)
      begin
         @(negedge Clk_CI);
         compare_value($sformatf("b%0d_valid", p), 80'(1), 80'(b_valid[p]));
         compare_value($sformatf("b%0d", p), 80'(seen), 80'(b[p]));
      end
      @(posedge Clk_CI);
      #2;
      b_ready[p] = 1'b1;
      @(negedge Clk_CI);
      compare_value($sformatf("b%0d_valid", p), 80'(1), 80'(b_valid[p]));
      @(posedge Clk_CI);
      #2;
      b_ready[p] = 1'b0;
      // One beat only
      @(negedge Clk_CI);
      compare_value($sformatf("b%0d_valid", p), 80'(0), 80'(b_valid[p]));
   endtask

   task automatic read_op(input int p, input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic [ID_W-1:0] id, input logic [1:0] exp_resp);
      bus_word_u ex;
      r_chan_t   seen;
      int        n;
      int        hold;
      // Addressed lane carries the word, the other lane stays zero
      ex.word              = '0;
      ex.lane[addr[2]]     = exp_data;
      @(posedge Clk_CI);
      #2;
      ar[p].id    = id;
      ar[p].addr  = addr;
      ar_valid[p] = 1'b1;
      n = 0;
      @(negedge Clk_CI);
      while (!ar_ready[p] && n < WAIT_LIMIT)
      begin
         @(negedge Clk_CI);
         n++;
      end
      check_waited(n, $sformatf("ar%0d_ready", p));
      if (hung)
         return;
      @(posedge Clk_CI);
      #2;
      ar_valid[p] = 1'b0;
      n = 0;
      @(negedge Clk_CI);
      while (!r_valid[p] && n < WAIT_LIMIT)
      begin
         @(negedge Clk_CI);
         n++;
      end
      check_waited(n, $sformatf("r%0d_valid", p));
      if (hung)
         return;
      assert (n == 0)
      else
      begin
         $display("r%0d_valid came %0d cycles later than one cycle after ar", p, n);
         op_errs++;
      end
      seen = r[p];
      compare_value($sformatf("r%0d.id", p), 80'(id), 80'(seen.id));
      compare_value($sformatf("r%0d.resp", p), 80'(exp_resp), 80'(seen.resp));
      compare_value($sformatf("r%0d.data", p), 80'(ex.word), 80'(seen.data.word));
      hold = next_rand() % 4;
      repeat (hold)
      begin
         @(negedge Clk_CI);
         compare_value($sformatf("r%0d_valid", p), 80'(1), 80'(r_valid[p]));
         compare_value($sformatf("r%0d", p), 80'(seen), 80'(r[p]));
      end
      @(posedge Clk_CI);
      #2;
      r_ready[p] = 1'b1;
      @(negedge Clk_CI);
      compare_value($sformatf("r%0d_valid", p), 80'(1), 80'(r_valid[p]));
      @(posedge Clk_CI);
      #2;
      r_ready[p] = 1'b0;
      @(negedge Clk_CI);
      compare_value($sformatf("r%0d_valid", p), 80'(0), 80'(r_valid[p]));
   endtask

   task automatic irq_op(input int p, input int limit, input logic exp);
      int n;
      n = 0;
      @(negedge Clk_CI);
      while (irq[p] !== exp && n < limit)
      begin
         @(negedge Clk_CI);
         n++;
      end
      compare_value($sformatf("irq%0d", p), 80'(exp), 80'(irq[p]));
   endtask

   task automatic finish_test(input string what);
      if (op_errs == 0)
      begin
         n_pass++;
         $display("%s: ok", what);
      end
      else
      begin
         n_fail++;
         $display("%s: failed with %0d errors", what, op_errs);
      end
   endtask

   initial
   begin
      int              fd;
      int              cnt;
      int              n;
      int              op_idx;
      int              port;
      int              kind;
      string           line;
      logic [31:0]     addr;
      logic [31:0]     data;
      logic [31:0]     strb;
      logic [31:0]     expv;
      logic [31:0]     resp;
      logic [ID_W-1:0] id;
      for (int p = 0; p < 2; p++)
      begin
         aw[p] = '0;
         w[p]  = '0;
         ar[p] = '0;
      end
      aw_valid = '0;
      w_valid  = '0;
      b_ready  = '0;
      ar_valid = '0;
      r_ready  = '0;
      hung     = 1'b0;
      n_pass   = 0;
      n_fail   = 0;
      op_errs  = 0;
      fd       = 0;

      n = 0;
      while (Rst_RBI !== 1'b1 && n < WAIT_LIMIT)
      begin
         @(posedge Clk_CI);
         n++;
      end
      check_waited(n, "reset release");
      @(negedge Clk_CI);
      compare_value("ready and valid outputs after reset", 80'(0),
                    80'({aw_ready, w_ready, b_valid, ar_ready, r_valid, irq}));
      finish_test("reset values");

      if (!hung)
         fd = $fopen("testbench/mbox_input.txt", "r");
      assert (hung || fd != 0)
      else
      begin
         $display("cannot open testbench/mbox_input.txt");
         hung = 1'b1;
      end

      op_idx = 0;
      while (!hung && $fgets(line, fd) > 0)
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         cnt = $sscanf(line, "%d %d %h %h %h %h %h", port, kind, addr, data, strb, expv, resp);
         assert (cnt == 7 && kind >= 0 && kind <= 2)
         else
         begin
            $display("input line could not be used: %s", line);
            n_fail++;
         end
         if (cnt != 7 || kind < 0 || kind > 2)
            continue;
         op_errs = 0;
         op_idx++;
         // Distinct IDs per operation
         id = ID_W'(op_idx * 97 + 5);
         case (kind)
            0: write_op(port, addr, data, strb[3:0], id, resp[1:0]);
            1: read_op(port, addr, expv, id, resp[1:0]);
            2: irq_op(port, data, expv[0]);
            default: ;
         endcase
         finish_test($sformatf("op %0d port %0d kind %0d addr %h", op_idx, port, kind, addr));
      end
      if (fd != 0)
         $fclose(fd);

      $display("tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0 && !hung && n_pass > 1)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
   (
    output logic Clk_CI,
    output logic Rst_RBI
    );

   // 40 ns period
   initial
   begin
      Clk_CI = 1'b0;
      forever #20 Clk_CI = ~Clk_CI;
   end

   initial
   begin
      Rst_RBI = 1'b0;
      repeat (4) @(posedge Clk_CI);
      #2;
      Rst_RBI = 1'b1;
   end

endmodule

// ==== hdl/mbox_top.sv ====
`timescale 1ns/1ps

module mbox_top
   (
    input  logic               Clk_CI,
    input  logic               Rst_RBI,

    input  mbox_pkg::aw_chan_t aw0,
    input  logic               aw0_valid,
    output logic               aw0_ready,
    input  mbox_pkg::w_chan_t  w0,
    input  logic               w0_valid,
    output logic               w0_ready,
    output mbox_pkg::b_chan_t  b0,
    output logic               b0_valid,
    input  logic               b0_ready,
    input  mbox_pkg::ar_chan_t ar0,
    input  logic               ar0_valid,
    output logic               ar0_ready,
    output mbox_pkg::r_chan_t  r0,
    output logic               r0_valid,
    input  logic               r0_ready,

    input  mbox_pkg::aw_chan_t aw1,
    input  logic               aw1_valid,
    output logic               aw1_ready,
    input  mbox_pkg::w_chan_t  w1,
    input  logic               w1_valid,
    output logic               w1_ready,
    output mbox_pkg::b_chan_t  b1,
    output logic               b1_valid,
    input  logic               b1_ready,
    input  mbox_pkg::ar_chan_t ar1,
    input  logic               ar1_valid,
    output logic               ar1_ready,
    output mbox_pkg::r_chan_t  r1,
    output logic               r1_valid,
    input  logic               r1_ready,

    output logic               irq0,
    output logic               irq1
    );

   import mbox_pkg::*;

   reg_req_t         req0, req1;
   logic             req0_valid, req1_valid, req0_ready, req1_ready;
   reg_rsp_t         rsp0, rsp1;
   logic             rsp0_valid, rsp1_valid, rsp0_ready, rsp1_ready;

   // f01 carries port 0 to port 1, f10 the reverse
   logic             push0, push1, pop0, pop1;
   logic [REG_W-1:0] push0_data, push1_data, f01_rd_data, f10_rd_data;
   logic             f01_full, f10_full, f01_empty, f10_empty;
   logic [LVL_W-1:0] f01_level, f10_level, thresh0, thresh1;
   logic [TMO_W-1:0] timeout0, timeout1;

   mbox_port_adapter i_adapter0
     (
      .Clk_CI, .Rst_RBI,
      .aw(aw0), .aw_valid(aw0_valid), .aw_ready(aw0_ready),
      .w(w0), .w_valid(w0_valid), .w_ready(w0_ready),
      .b(b0), .b_valid(b0_valid), .b_ready(b0_ready),
      .ar(ar0), .ar_valid(ar0_valid), .ar_ready(ar0_ready),
      .r(r0), .r_valid(r0_valid), .r_ready(r0_ready),
      .req(req0), .req_valid(req0_valid), .req_ready(req0_ready),
      .rsp(rsp0), .rsp_valid(rsp0_valid), .rsp_ready(rsp0_ready)
      );

   mbox_port_adapter i_adapter1
     (
      .Clk_CI, .Rst_RBI,
      .aw(aw1), .aw_valid(aw1_valid), .aw_ready(aw1_ready),
      .w(w1), .w_valid(w1_valid), .w_ready(w1_ready),
      .b(b1), .b_valid(b1_valid), .b_ready(b1_ready),
      .ar(ar1), .ar_valid(ar1_valid), .ar_ready(ar1_ready),
      .r(r1), .r_valid(r1_valid), .r_ready(r1_ready),
      .req(req1), .req_valid(req1_valid), .req_ready(req1_ready),
      .rsp(rsp1), .rsp_valid(rsp1_valid), .rsp_ready(rsp1_ready)
      );

   mbox_access_fsm i_fsm0
     (
      .Clk_CI, .Rst_RBI,
      .req(req0), .req_valid(req0_valid), .req_ready(req0_ready),
      .rsp(rsp0), .rsp_valid(rsp0_valid), .rsp_ready(rsp0_ready),
      .push(push0), .push_data(push0_data), .out_full(f01_full),
      .pop(pop0), .in_rd_data(f10_rd_data), .in_empty(f10_empty), .in_level(f10_level),
      .thresh(thresh0), .timeout(timeout0)
      );

   mbox_access_fsm i_fsm1
     (
      .Clk_CI, .Rst_RBI,
      .req(req1), .req_valid(req1_valid), .req_ready(req1_ready),
      .rsp(rsp1), .rsp_valid(rsp1_valid), .rsp_ready(rsp1_ready),
      .push(push1), .push_data(push1_data), .out_full(f10_full),
      .pop(pop1), .in_rd_data(f01_rd_data), .in_empty(f01_empty), .in_level(f01_level),
      .thresh(thresh1), .timeout(timeout1)
      );

   mbox_fifo i_fifo01
     (
      .Clk_CI, .Rst_RBI,
      .push(push0), .push_data(push0_data), .pop(pop1),
      .rd_data(f01_rd_data), .full(f01_full), .empty(f01_empty), .level(f01_level)
      );

   mbox_fifo i_fifo10
     (
      .Clk_CI, .Rst_RBI,
      .push(push1), .push_data(push1_data), .pop(pop0),
      .rd_data(f10_rd_data), .full(f10_full), .empty(f10_empty), .level(f10_level)
      );

   mbox_irq_timer i_irq0
     (
      .Clk_CI, .Rst_RBI,
      .level(f10_level), .empty(f10_empty), .pop(pop0),
      .thresh(thresh0), .timeout(timeout0), .irq(irq0)
      );

   mbox_irq_timer i_irq1
     (
      .Clk_CI, .Rst_RBI,
      .level(f01_level), .empty(f01_empty), .pop(pop1),
      .thresh(thresh1), .timeout(timeout1), .irq(irq1)
      );

endmodule

// ==== hdl/mbox_port_adapter.sv ====
`timescale 1ns/1ps

module mbox_port_adapter
   (
    input  logic               Clk_CI,
    input  logic               Rst_RBI,

    input  mbox_pkg::aw_chan_t aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  mbox_pkg::w_chan_t  w,
    input  logic               w_valid,
    output logic               w_ready,
    output mbox_pkg::b_chan_t  b,
    output logic               b_valid,
    input  logic               b_ready,
    input  mbox_pkg::ar_chan_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output mbox_pkg::r_chan_t  r,
    output logic               r_valid,
    input  logic               r_ready,

    output mbox_pkg::reg_req_t req,
    output logic               req_valid,
    input  logic               req_ready,
    input  mbox_pkg::reg_rsp_t rsp,
    input  logic               rsp_valid,
    output logic               rsp_ready
    );

   import mbox_pkg::*;

   aw_chan_t        aw_q;
   logic            aw_held_q;
   logic            aw_ready_q;
   logic            wr_lane;
   logic            sel_write;
   logic            accept;
   logic            rsp_write_q;
   logic            rd_lane_q;
   logic [ID_W-1:0] rsp_id_q;

   assign aw_ready  = aw_ready_q;
   assign wr_lane   = aw_q.addr[2];

   // Write wins once address and data are both there
   assign sel_write = aw_held_q & w_valid;
   assign req_valid = sel_write | ar_valid;
   assign accept    = req_valid & req_ready;
   assign w_ready   = req_ready & sel_write;
   assign ar_ready  = req_ready & ~sel_write;

   always_comb
   begin
      req.write = sel_write;
      if (sel_write)
      begin
         req.idx   = aw_q.addr[4:3];
         req.wdata = w.data.lane[wr_lane];
         req.wstrb = w.strb[wr_lane*REG_STRB_W +: REG_STRB_W];
      end
      else
      begin
         req.idx   = ar.addr[4:3];
         req.wdata = '0;
         req.wstrb = '0;
      end
   end

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (Rst_RBI == 1'b0)
      begin
         aw_ready_q  <= 1'b0;
         aw_held_q   <= 1'b0;
         rsp_write_q <= 1'b0;
      end
      else
      begin
         // One-cycle ready pulse, a cycle after valid
         aw_ready_q <= aw_valid & ~aw_held_q & ~aw_ready_q;
         if (aw_valid & aw_ready_q)
            aw_held_q <= 1'b1;
         else if (accept & sel_write)
            aw_held_q <= 1'b0;
         if (accept)
            rsp_write_q <= sel_write;
      end
   end

   always_ff @(posedge Clk_CI)
   begin
      if (aw_valid & aw_ready_q)
         aw_q <= aw;
      if (accept)
      begin
         rsp_id_q  <= sel_write ? aw_q.id : ar.id;
         rd_lane_q <= ar.addr[2];
      end
   end

   assign b_valid   = rsp_valid & rsp_write_q;
   assign r_valid   = rsp_valid & ~rsp_write_q;
   assign rsp_ready = rsp_write_q ? b_ready : r_ready;

   // IDs only shown while the response is valid
   always_comb
   begin
      b.id   = b_valid ? rsp_id_q : '0;
      b.resp = rsp.resp;
      r.id   = r_valid ? rsp_id_q : '0;
      r.resp = rsp.resp;
      r.data.word = '0;
      r.data.lane[rd_lane_q] = rsp.rdata;
   end

endmodule

// ==== hdl/mbox_access_fsm.sv ====
`timescale 1ns/1ps

module mbox_access_fsm
   (
    input  logic                         Clk_CI,
    input  logic                         Rst_RBI,

    input  mbox_pkg::reg_req_t           req,
    input  logic                         req_valid,
    output logic                         req_ready,
    output mbox_pkg::reg_rsp_t           rsp,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,

    output logic                         push,
    output logic [mbox_pkg::REG_W-1:0]   push_data,
    input  logic                         out_full,
    output logic                         pop,
    input  logic [mbox_pkg::REG_W-1:0]   in_rd_data,
    input  logic                         in_empty,
    input  logic [mbox_pkg::LVL_W-1:0]   in_level,

    output logic [mbox_pkg::LVL_W-1:0]   thresh,
    output logic [mbox_pkg::TMO_W-1:0]   timeout
    );

   import mbox_pkg::*;

   logic [ST_W-1:0]  state_q;
   logic [ST_W-1:0]  state_d;
   logic             acc;
   reg_rsp_t         rsp_d;
   logic [LVL_W-1:0] thresh_d;
   logic [TMO_W-1:0] timeout_d;

   assign req_ready = (state_q == ST_ACCEPT);
   assign rsp_valid = (state_q == ST_RESP);
   assign acc       = req_ready & req_valid;

   // Unstrobed bytes go into the FIFO as zero
   always_comb
   begin
      for (int i = 0; i < REG_STRB_W; i++)
         push_data[8*i +: 8] = req.wstrb[i] ? req.wdata[8*i +: 8] : 8'h00;
   end

   always_comb
   begin
      push       = 1'b0;
      pop        = 1'b0;
      thresh_d   = thresh;
      timeout_d  = timeout;
      rsp_d.rdata = '0;
      rsp_d.resp  = RESP_OKAY;
      if (acc)
      begin
         case (req.idx)
            OFS_DATA[4:3]:
               if (req.write)
               begin
                  if (out_full)
                     rsp_d.resp = RESP_SLVERR;
                  else
                     push = 1'b1;
               end
               else if (in_empty)
                  rsp_d.resp = RESP_SLVERR;
               else
               begin
                  pop         = 1'b1;
                  rsp_d.rdata = in_rd_data;
               end
            OFS_STATUS[4:3]:
               if (req.write)
                  rsp_d.resp = RESP_SLVERR;
               else
                  rsp_d.rdata = REG_W'({in_level, out_full, in_empty});
            OFS_THRESH[4:3]:
            begin
               if (req.write & req.wstrb[0])
                  thresh_d = req.wdata[LVL_W-1:0];
               rsp_d.rdata = REG_W'(thresh);
            end
            OFS_TIMEOUT[4:3]:
            begin
               if (req.write & req.wstrb[0])
                  timeout_d[7:0] = req.wdata[7:0];
               if (req.write & req.wstrb[1])
                  timeout_d[15:8] = req.wdata[15:8];
               rsp_d.rdata = REG_W'(timeout);
            end
         endcase
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:
            if (req_valid)
               state_d = ST_ACCEPT;
         ST_ACCEPT:
            state_d = req_valid ? ST_RESP : ST_IDLE;
         ST_RESP:
            if (rsp_ready)
               state_d = ST_IDLE;
         default:
            state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (Rst_RBI == 1'b0)
      begin
         state_q <= ST_IDLE;
         thresh  <= '0;
         timeout <= '0;
      end
      else
      begin
         state_q <= state_d;
         thresh  <= thresh_d;
         timeout <= timeout_d;
      end
   end

   always_ff @(posedge Clk_CI)
   begin
      if (acc)
         rsp <= rsp_d;
   end

endmodule

// ==== hdl/mbox_irq_timer.sv ====
`timescale 1ns/1ps

module mbox_irq_timer
   (
    input  logic                       Clk_CI,
    input  logic                       Rst_RBI,

    input  logic [mbox_pkg::LVL_W-1:0] level,
    input  logic                       empty,
    input  logic                       pop,
    input  logic [mbox_pkg::LVL_W-1:0] thresh,
    input  logic [mbox_pkg::TMO_W-1:0] timeout,
    output logic                       irq
    );

   import mbox_pkg::*;

   logic [TMO_W-1:0] wait_q;
   logic             thr_hit;
   logic             tmo_hit;

   // A zero threshold or timeout disables that rule
   assign thr_hit = (thresh != '0) && (level >= thresh);
   assign tmo_hit = (timeout != '0) && (wait_q >= timeout);

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (Rst_RBI == 1'b0)
      begin
         wait_q <= '0;
         irq    <= 1'b0;
      end
      else
      begin
         // Restart on every read by the local master
         if (empty | pop)
            wait_q <= '0;
         else if (wait_q < timeout)
            wait_q <= wait_q + 1'b1;
         irq <= thr_hit | tmo_hit;
      end
   end

endmodule

// ==== hdl/mbox_fifo.sv ====
`timescale 1ns/1ps

module mbox_fifo
   (
    input  logic                       Clk_CI,
    input  logic                       Rst_RBI,

    input  logic                       push,
    input  logic [mbox_pkg::REG_W-1:0] push_data,
    input  logic                       pop,
    output logic [mbox_pkg::REG_W-1:0] rd_data,
    output logic                       full,
    output logic                       empty,
    output logic [mbox_pkg::LVL_W-1:0] level
    );

   import mbox_pkg::*;

   logic [REG_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic             do_push;
   logic             do_pop;

   assign full    = (level == LVL_W'(FIFO_DEPTH));
   assign empty   = (level == '0);
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;
   assign rd_data = mem[rd_ptr_q];

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (Rst_RBI == 1'b0)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level    <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_push & ~do_pop)
            level <= level + 1'b1;
         else if (do_pop & ~do_push)
            level <= level - 1'b1;
      end
   end

   always_ff @(posedge Clk_CI)
   begin
      if (do_push)
         mem[wr_ptr_q] <= push_data;
   end

endmodule

// ==== hdl/mbox_pkg.sv ====
package mbox_pkg;

   localparam int ADDR_W     = 32;
   localparam int ID_W       = 10;
   localparam int BUS_W      = 64;
   localparam int STRB_W     = BUS_W/8;
   localparam int REG_W      = 32;
   localparam int REG_STRB_W = REG_W/8;
   localparam int LANES      = BUS_W/REG_W;
   localparam int FIFO_DEPTH = 8;
   localparam int PTR_W      = 3;
   localparam int LVL_W      = 4;
   localparam int TMO_W      = 16;
   localparam int IDX_W      = 2;
   localparam int RESP_W     = 2;
   localparam int ST_W       = 2;

   // Register window, decoded on address bits 4:3
   localparam logic [4:0] OFS_DATA    = 5'h00;
   localparam logic [4:0] OFS_STATUS  = 5'h08;
   localparam logic [4:0] OFS_THRESH  = 5'h10;
   localparam logic [4:0] OFS_TIMEOUT = 5'h18;

   localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
   localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

   localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;
   localparam logic [ST_W-1:0] ST_ACCEPT = 2'd1;
   localparam logic [ST_W-1:0] ST_RESP   = 2'd2;

   // Full bus word or its two 32-bit lanes
   typedef union packed {
      logic [BUS_W-1:0]            word;
      logic [LANES-1:0][REG_W-1:0] lane;
   } bus_word_u;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
   } aw_chan_t;

   typedef struct packed {
      bus_word_u         data;
      logic [STRB_W-1:0] strb;
   } w_chan_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [RESP_W-1:0] resp;
   } b_chan_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
   } ar_chan_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      bus_word_u         data;
      logic [RESP_W-1:0] resp;
   } r_chan_t;

   typedef struct packed {
      logic                  write;
      logic [IDX_W-1:0]      idx;
      logic [REG_W-1:0]      wdata;
      logic [REG_STRB_W-1:0] wstrb;
   } reg_req_t;

   typedef struct packed {
      logic [REG_W-1:0]  rdata;
      logic [RESP_W-1:0] resp;
   } reg_rsp_t;

endpackage
